// ==== adc_frontend.sv ====
////////////////////////////////////////////////////////////
// ADC front end
// Pin capture, code conversion and digital loopback mux
////////////////////////////////////////////////////////////

module adc_frontend
  import analog_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_i,
  // ADC pins
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  // Loopback from DAC side
  input  logic                 digital_loop_i,
  input  sample_t              loop_a_i,     // Saturated DAC value, channel A
  input  sample_t              loop_b_i,     // Saturated DAC value, channel B
  // Samples to the datapath
  output sample_t              smp_a_o,
  output sample_t              smp_b_o
);

  logic [SMP_W-1:0] raw_a;  // Registered pin code A
  logic [SMP_W-1:0] raw_b;  // Registered pin code B
  sample_t          cnv_a;
  sample_t          cnv_b;

  ////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////

  // Lowest two bits are reserved for a 16-bit ADC
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      raw_a <= neg_slope('0);  // Mid-scale code, reads as 0
      raw_b <= neg_slope('0);
    end
    else
    begin
      raw_a <= adc_dat_a_i[ADC_PIN_W-1:ADC_PIN_W-SMP_W];
      raw_b <= adc_dat_b_i[ADC_PIN_W-1:ADC_PIN_W-SMP_W];
    end
  end

  // Unsigned negative slope into two's complement
  assign cnv_a = neg_slope(raw_a);
  assign cnv_b = neg_slope(raw_b);

  // Loopback replaces both channels at once
  assign smp_a_o = digital_loop_i ? loop_a_i : cnv_a;
  assign smp_b_o = digital_loop_i ? loop_b_i : cnv_b;

endmodule : adc_frontend

// ==== all.f ====
analog_pkg.sv
regmap_pkg.sv
adc_frontend.sv
p_controller.sv
dac_backend.sv
housekeeping_regs.sv
analog_top.sv
tb_analog_top.sv

// ==== analog_pkg.sv ====
////////////////////////////////////////////////////////////
// Analog datapath definitions
// Sample and gain widths, limits and converter coding
////////////////////////////////////////////////////////////

package analog_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int ADC_PIN_W = 16;  // ADC pin word, two reserved LSBs
  localparam int SMP_W     = 14;  // Converter resolution
  localparam int SUM_W     = 15;  // Generator plus feedback, one guard bit
  localparam int GAIN_W    = 16;  // Signed gain word

  // Gain fraction bits, 4096 is unity
  localparam int GAIN_SHIFT = 12;

  // Full sample-times-gain product
  localparam int PROD_W = SMP_W + GAIN_W;

  // Two's complement sample as used inside the FPGA
  typedef logic signed [SMP_W-1:0] sample_t;

  ////////////////////////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////////////////////////

  localparam sample_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};  // +8191
  localparam sample_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};  // -8192

  // Converter code <-> two's complement
  // Both converters use a negative slope, so the mapping is
  // its own inverse: keep the MSB, flip the rest
  function automatic logic [SMP_W-1:0] neg_slope(input logic [SMP_W-1:0] d);
    return {d[SMP_W-1], ~d[SMP_W-2:0]};
  endfunction

endpackage : analog_pkg

// ==== analog_top.sv ====
////////////////////////////////////////////////////////////
// Analog path top level
// ADC in, P feedback plus set-point, DAC out, bus registers
////////////////////////////////////////////////////////////

module analog_top
  import analog_pkg::*;
  import regmap_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_i,
  // ADC
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  // DAC, parallel words per channel
  output logic [SMP_W-1:0]     dac_dat_a_o,
  output logic [SMP_W-1:0]     dac_dat_b_o,
  output logic [LED_W-1:0]     led_o,
  // System bus
  input  logic [ADDR_W-1:0]    addr_i,
  input  logic [DATA_W-1:0]    wdata_i,
  input  logic                 wen_i,
  input  logic                 ren_i,
  output logic [DATA_W-1:0]    rdata_o,
  output logic                 ack_o,
  output logic                 err_o
);

  sample_t                  smp_a, smp_b;    // Front end samples
  sample_t                  fb_a, fb_b;      // P terms
  sample_t                  set_a, set_b;    // Set-points
  sample_t                  loop_a, loop_b;  // Saturated DAC values
  logic signed [GAIN_W-1:0] gain_a, gain_b;
  logic                     digital_loop;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .rst_i          (rst_i       ),
    .adc_dat_a_i    (adc_dat_a_i ),
    .adc_dat_b_i    (adc_dat_b_i ),
    .digital_loop_i (digital_loop),
    .loop_a_i       (loop_a      ),
    .loop_b_i       (loop_b      ),
    .smp_a_o        (smp_a       ),
    .smp_b_o        (smp_b       )
  );

  p_controller i_pctl_a (.adc_clk (adc_clk), .rst_i (rst_i), .smp_i (smp_a), .gain_i (gain_a),
                         .fb_o (fb_a));
  p_controller i_pctl_b (.adc_clk (adc_clk), .rst_i (rst_i), .smp_i (smp_b), .gain_i (gain_b),
                         .fb_o (fb_b));

  dac_backend i_dac (
    .adc_clk     (adc_clk    ),
    .rst_i       (rst_i      ),
    .set_a_i     (set_a      ),
    .set_b_i     (set_b      ),
    .fb_a_i      (fb_a       ),
    .fb_b_i      (fb_b       ),
    .loop_a_o    (loop_a     ),  // Back to front end
    .loop_b_o    (loop_b     ),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  ////////////////////////////////////////////////////////////
  // Housekeeping
  ////////////////////////////////////////////////////////////

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk     ),
    .rst_i          (rst_i       ),
    .addr_i         (addr_i      ),
    .wdata_i        (wdata_i     ),
    .wen_i          (wen_i       ),
    .ren_i          (ren_i       ),
    .rdata_o        (rdata_o     ),
    .ack_o          (ack_o       ),
    .err_o          (err_o       ),
    .smp_a_i        (smp_a       ),
    .smp_b_i        (smp_b       ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       ),
    .set_a_o        (set_a       ),
    .set_b_o        (set_b       ),
    .gain_a_o       (gain_a      ),
    .gain_b_o       (gain_b      )
  );

endmodule : analog_top

// ==== dac_backend.sv ====
////////////////////////////////////////////////////////////
// DAC back end
// Generator plus feedback, saturation and DAC coding
////////////////////////////////////////////////////////////

module dac_backend
  import analog_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_i,
  // Generator set-points
  input  sample_t          set_a_i,
  input  sample_t          set_b_i,
  // Feedback terms
  input  sample_t          fb_a_i,
  input  sample_t          fb_b_i,
  // Saturated values, ahead of the output register
  output sample_t          loop_a_o,
  output sample_t          loop_b_o,
  // DAC codes
  output logic [SMP_W-1:0] dac_dat_a_o,
  output logic [SMP_W-1:0] dac_dat_b_o
);

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;

  // Clip a 15-bit sum back into 14 bits
  // Overflow shows as differing top two bits
  function automatic sample_t sat_sum(input logic signed [SUM_W-1:0] s);
    if (s[SUM_W-1] ^ s[SUM_W-2])
      return s[SUM_W-1] ? SMP_MIN : SMP_MAX;
    return s[SMP_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Summation and saturation
  ////////////////////////////////////////////////////////////

  assign sum_a = set_a_i + fb_a_i;  // Sign extended to SUM_W
  assign sum_b = set_b_i + fb_b_i;

  assign loop_a_o = sat_sum(sum_a);
  assign loop_b_o = sat_sum(sum_b);

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  // Two's complement back to negative-slope code
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= neg_slope('0);  // Code for 0, mid-scale
      dac_dat_b_o <= neg_slope('0);
    end
    else
    begin
      dac_dat_a_o <= neg_slope(loop_a_o);
      dac_dat_b_o <= neg_slope(loop_b_o);
    end
  end

  // Catches undriven set-points or feedback upstream
  a_dac_known : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !$isunknown({dac_dat_a_o, dac_dat_b_o})
  );

endmodule : dac_backend

// ==== housekeeping_regs.sv ====
////////////////////////////////////////////////////////////
// Housekeeping registers
// System bus access to config, set-points, gains and LEDs
////////////////////////////////////////////////////////////

module housekeeping_regs
  import analog_pkg::*;
  import regmap_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     rst_i,
  // System bus
  input  logic [ADDR_W-1:0]        addr_i,
  input  logic [DATA_W-1:0]        wdata_i,
  input  logic                     wen_i,
  input  logic                     ren_i,
  output logic [DATA_W-1:0]        rdata_o,
  output logic                     ack_o,
  output logic                     err_o,
  // Sample readback
  input  sample_t                  smp_a_i,
  input  sample_t                  smp_b_i,
  // Configuration outputs
  output logic                     digital_loop_o,
  output logic [LED_W-1:0]         led_o,
  output sample_t                  set_a_o,
  output sample_t                  set_b_o,
  output logic signed [GAIN_W-1:0] gain_a_o,
  output logic signed [GAIN_W-1:0] gain_b_o
);

  logic [DATA_W-1:0] rd_val;  // Read mux
  logic              hit;     // Address is mapped
  logic              ro;      // Read-only register

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    ro     = 1'b0;
    rd_val = '0;
    case (reg_addr_e'(addr_i))
      REG_ID:
      begin
        rd_val = ID_VALUE;
        ro     = 1'b1;
      end
      REG_CFG:    rd_val[CFG_LOOP_BIT] = digital_loop_o;
      REG_LED:    rd_val[LED_W-1:0] = led_o;
      REG_SET_A:  rd_val = {{(DATA_W-SMP_W){set_a_o[SMP_W-1]}}, set_a_o};
      REG_SET_B:  rd_val = {{(DATA_W-SMP_W){set_b_o[SMP_W-1]}}, set_b_o};
      REG_GAIN_A: rd_val = {{(DATA_W-GAIN_W){gain_a_o[GAIN_W-1]}}, gain_a_o};
      REG_GAIN_B: rd_val = {{(DATA_W-GAIN_W){gain_b_o[GAIN_W-1]}}, gain_b_o};
      REG_ADC_A:
      begin
        rd_val = {{(DATA_W-SMP_W){smp_a_i[SMP_W-1]}}, smp_a_i};
        ro     = 1'b1;
      end
      REG_ADC_B:
      begin
        rd_val = {{(DATA_W-SMP_W){smp_b_i[SMP_W-1]}}, smp_b_i};
        ro     = 1'b1;
      end
      default:    hit = 1'b0;  // Unmapped
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Writes land on the ack cycle
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= CFG_RST[CFG_LOOP_BIT];
      led_o          <= LED_RST[LED_W-1:0];
      set_a_o        <= SET_RST[SMP_W-1:0];
      set_b_o        <= SET_RST[SMP_W-1:0];
      gain_a_o       <= GAIN_RST[GAIN_W-1:0];
      gain_b_o       <= GAIN_RST[GAIN_W-1:0];
    end
    else if (wen_i)
    begin
      case (reg_addr_e'(addr_i))
        REG_CFG:    digital_loop_o <= wdata_i[CFG_LOOP_BIT];
        REG_LED:    led_o          <= wdata_i[LED_W-1:0];
        REG_SET_A:  set_a_o        <= wdata_i[SMP_W-1:0];
        REG_SET_B:  set_b_o        <= wdata_i[SMP_W-1:0];
        REG_GAIN_A: gain_a_o       <= wdata_i[GAIN_W-1:0];
        REG_GAIN_B: gain_b_o       <= wdata_i[GAIN_W-1:0];
        default:    ;  // Read-only or unmapped, no effect
      endcase
    end
  end

  // Ack, error and read data, one cycle after the request
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o   <= wen_i | ren_i;
      err_o   <= (ren_i & ~hit) | (wen_i & (~hit | ro));
      rdata_o <= ren_i ? rd_val : '0;  // Zero outside ack
    end
  end

  // Bus master never issues both strobes
  a_one_strobe : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !(wen_i && ren_i)
  );

endmodule : housekeeping_regs

// ==== p_controller.sv ====
////////////////////////////////////////////////////////////
// Proportional controller
// Gain-scaled, saturated feedback term for one channel
////////////////////////////////////////////////////////////

module p_controller
  import analog_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  sample_t                  smp_i,   // Input sample
  input  logic signed [GAIN_W-1:0] gain_i,  // Q4.12 gain
  output sample_t                  fb_o     // Registered feedback term
);

  logic signed [PROD_W-1:0] prod;      // Full precision product
  logic signed [PROD_W-1:0] prod_shr;  // Scaled, floored
  sample_t                  sat;

  ////////////////////////////////////////////////////////////
  // Multiply and scale
  ////////////////////////////////////////////////////////////

  assign prod = smp_i * gain_i;  // Both signed, no overflow at 30 bits

  // Arithmetic shift rounds toward minus infinity
  assign prod_shr = prod >>> GAIN_SHIFT;

  // Clip to the 14-bit range
  always_comb
  begin
    if (prod_shr > SMP_MAX)
      sat = SMP_MAX;
    else if (prod_shr < SMP_MIN)
      sat = SMP_MIN;
    else
      sat = prod_shr[SMP_W-1:0];  // Fits, drop sign copies
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  // Also breaks the loopback path back into the front end
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      fb_o <= '0;
    else
      fb_o <= sat;
  end

  // Scaling and clipping keep the sign of the product
  a_fb_sign : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    1'b1 |=> (fb_o[SMP_W-1] == $past(prod[PROD_W-1]))
  );

endmodule : p_controller

// ==== regmap_pkg.sv ====
////////////////////////////////////////////////////////////
// Housekeeping register map
// Bus widths, register addresses, ID and reset values
////////////////////////////////////////////////////////////

package regmap_pkg;

  localparam int ADDR_W = 8;   // Byte address, word aligned
  localparam int DATA_W = 32;  // Bus data word
  localparam int LED_W  = 8;   // LED register width

  localparam int CFG_LOOP_BIT = 0;  // CFG bit for digital loopback

  // Register offsets
  typedef enum logic [ADDR_W-1:0] {
    REG_ID     = 8'h00,  // Read only
    REG_CFG    = 8'h04,  // Bit 0 digital_loop
    REG_LED    = 8'h08,
    REG_SET_A  = 8'h0C,  // 14-bit signed set-point
    REG_SET_B  = 8'h10,
    REG_GAIN_A = 8'h14,  // 16-bit signed gain
    REG_GAIN_B = 8'h18,
    REG_ADC_A  = 8'h1C,  // Read only sample
    REG_ADC_B  = 8'h20
  } reg_addr_e;

  // Identification word
  localparam logic [DATA_W-1:0] ID_VALUE = 32'h5250_0100;

  ////////////////////////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////////////////////////

  localparam logic [DATA_W-1:0] CFG_RST  = '0;
  localparam logic [DATA_W-1:0] LED_RST  = '0;
  localparam logic [DATA_W-1:0] SET_RST  = '0;
  localparam logic [DATA_W-1:0] GAIN_RST = '0;

endpackage : regmap_pkg

// ==== run_sim.sh ====
#!/bin/sh
# Builds the analog path testbench with Verilator and runs it.
# Exit status is 0 only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_analog_top \
  -f all.f \
  -o tb_analog_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_analog_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_analog_top.sv ====
////////////////////////////////////////////////////////////
// Analog path testbench
// Bus register checks and table-driven DAC code checks
////////////////////////////////////////////////////////////

module tb_analog_top
  import analog_pkg::*;
  import regmap_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS  = 11;
  localparam int CYC_LIMIT = NUM_ROWS * 40 + 2000;  // Watchdog

  logic adc_clk, rst_i, wen_i, ren_i, ack_o, err_o;
  logic [15:0] adc_dat_a_i, adc_dat_b_i;
  logic [13:0] dac_dat_a_o, dac_dat_b_o;
  logic [7:0]  led_o, addr_i;
  logic [31:0] wdata_i, rdata_o;

  logic [31:0] lfsr = 32'h92fb;
  int cycles, checks, errors, test_no, err_at_start;

  // Stimulus table, one row per DAC check
  logic [15:0] row_pin_a [NUM_ROWS];
  logic [15:0] row_pin_b [NUM_ROWS];
  logic [15:0] row_gain_a [NUM_ROWS];
  logic [15:0] row_gain_b [NUM_ROWS];
  int          row_set_a [NUM_ROWS];
  int          row_set_b [NUM_ROWS];
  logic        row_loop [NUM_ROWS];
  logic [13:0] row_exp_a [NUM_ROWS];
  logic [13:0] row_exp_b [NUM_ROWS];

  analog_top i_dut (.*);

  always #20 adc_clk = ~adc_clk;

  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYC_LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////////////////////////

  // Pin word to signed sample, MSB kept, rest inverted
  function automatic int adc_value(input logic [15:0] pin);
    logic [13:0] code;
    logic [13:0] twos;
    code = pin[15:2];  // Reserved LSBs dropped
    twos = {code[13], ~code[12:0]};
    return int'($signed(twos));
  endfunction

  function automatic logic [15:0] pin_of(input int v);
    logic [13:0] t;
    t = v[13:0];
    return {t[13], ~t[12:0], 2'b11};  // Reserved bits set, ignored by DUT
  endfunction

  function automatic int clip(input longint v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return int'(v);
  endfunction

  function automatic int p_term(input int smp, input logic [15:0] gain);
    longint prod;
    prod = longint'(smp) * longint'($signed(gain));
    return clip(prod >>> 12);  // Floor, 4096 is unity
  endfunction

  function automatic logic [13:0] dac_code(input int v);
    logic [13:0] t;
    t = v[13:0];
    return {t[13], ~t[12:0]};
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus access and checks
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // One strobe cycle, then wait for ack with a limit
  task automatic bus_cycle(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    addr_i  <= addr;
    wdata_i <= data;
    wen_i   <= wr;
    ren_i   <= ~wr;
    @(posedge adc_clk);
    wen_i <= 1'b0;
    ren_i <= 1'b0;
    @(negedge adc_clk);
    while (!ack_o && waited < 8)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!ack_o)
    begin
      $display("Bus access to address 0x%h was never acknowledged", addr);
      errors++;
    end
    else if (waited != 0)
    begin
      $display("Bus access to address 0x%h was acknowledged %0d cycles late", addr, waited);
      errors++;
    end
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_cycle(1'b1, addr, data, rd, err);
    check("err_o", 32'(err), 32'(exp_err));
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    logic        err;
    bus_cycle(1'b0, addr, '0, rd, err);
    check(name, rd, exp);
    check("err_o", 32'(err), 32'd0);
  endtask

  task automatic end_test(input string name);
    test_no++;
    if (errors == err_at_start)
      $display("Test %0d %s: ok", test_no, name);
    else
      $display("Test %0d %s: %0d errors", test_no, name, errors - err_at_start);
    err_at_start = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////

  task automatic set_row(input int i, input logic [15:0] ga, input logic [15:0] gb,
                         input int sa, input int sb, input logic lp);
    logic [31:0] r;
    rand_bits(16, r);
    row_pin_a[i] = r[15:0];
    rand_bits(16, r);
    row_pin_b[i] = r[15:0];
    row_gain_a[i] = ga;
    row_gain_b[i] = gb;
    row_set_a[i]  = sa;
    row_set_b[i]  = sb;
    row_loop[i]   = lp;
  endtask

  task automatic build_table();
    int smp_a, smp_b;
    set_row(0, 16'h0000, 16'h0000, 8191, -8192, 1'b0);   // Generator only
    set_row(1, 16'h0000, 16'h0000, -8192, 8191, 1'b0);
    set_row(2, 16'h0000, 16'h0000, 0, 1234, 1'b0);
    set_row(3, 16'h0000, 16'h0000, -1, -4000, 1'b1);     // Loopback, zero gain
    set_row(4, 16'h1000, 16'h1000, 0, 0, 1'b0);          // Unity
    set_row(5, 16'h0800, 16'hF000, 100, -100, 1'b0);     // Half and minus one
    set_row(6, 16'h0555, 16'hFFFF, -500, 7, 1'b0);       // Small fraction, floors
    set_row(7, 16'h7FFF, 16'h8000, 0, 0, 1'b0);          // About +8 and -8
    set_row(8, 16'h1000, 16'h1000, 6000, -6000, 1'b0);
    set_row(9, 16'h7FFF, 16'h7FFF, 0, 0, 1'b0);
    set_row(10, 16'hF000, 16'hF000, 300, -300, 1'b0);
    row_pin_a[8]  = pin_of(5000);   // Sum clips high
    row_pin_b[8]  = pin_of(-5000);  // Sum clips low
    row_pin_a[9]  = pin_of(8191);   // Controller clips
    row_pin_b[9]  = pin_of(-8192);
    row_pin_a[10] = pin_of(-8192);  // Negated full scale overflows
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      // Loop rows use zero gain, so the sample is the set-point
      smp_a = row_loop[i] ? clip(row_set_a[i]) : adc_value(row_pin_a[i]);
      smp_b = row_loop[i] ? clip(row_set_b[i]) : adc_value(row_pin_b[i]);
      row_exp_a[i] = dac_code(clip(row_set_a[i] + p_term(smp_a, row_gain_a[i])));
      row_exp_b[i] = dac_code(clip(row_set_b[i] + p_term(smp_b, row_gain_b[i])));
    end
  endtask

  task automatic apply_rows(input int first, input int last);
    for (int i = first; i < last; i++)
    begin
      write_reg(REG_CFG, 32'(row_loop[i]), 1'b0);  // Loop bit first
      write_reg(REG_GAIN_A, 32'(row_gain_a[i]), 1'b0);
      write_reg(REG_GAIN_B, 32'(row_gain_b[i]), 1'b0);
      write_reg(REG_SET_A, 32'(row_set_a[i]), 1'b0);
      write_reg(REG_SET_B, 32'(row_set_b[i]), 1'b0);
      @(posedge adc_clk);
      adc_dat_a_i <= row_pin_a[i];
      adc_dat_b_i <= row_pin_b[i];
      repeat (4) @(posedge adc_clk);  // Pin to DAC is 3 cycles
      @(negedge adc_clk);
      check("dac_dat_a_o", 32'(dac_dat_a_o), 32'(row_exp_a[i]));
      check("dac_dat_b_o", 32'(dac_dat_b_o), 32'(row_exp_b[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    logic [15:0] pa, pb;
    adc_clk = 1'b0;
    rst_i   = 1'b1;
    wen_i   = 1'b0;
    ren_i   = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    adc_dat_a_i = pin_of(0);  // Mid-scale code
    adc_dat_b_i = pin_of(0);
    build_table();
    repeat (16) @(posedge adc_clk);
    rst_i <= 1'b0;

    // Reset values, DAC codes still from the reset branch
    @(negedge adc_clk);
    check("dac_dat_a_o", 32'(dac_dat_a_o), 32'h1FFF);
    check("dac_dat_b_o", 32'(dac_dat_b_o), 32'h1FFF);
    read_reg(REG_ID, ID_VALUE, "rdata_o (ID)");
    read_reg(REG_CFG, 0, "rdata_o (CFG)");
    read_reg(REG_LED, 0, "rdata_o (LED)");
    read_reg(REG_SET_A, 0, "rdata_o (SET_A)");
    read_reg(REG_SET_B, 0, "rdata_o (SET_B)");
    read_reg(REG_GAIN_A, 0, "rdata_o (GAIN_A)");
    read_reg(REG_GAIN_B, 0, "rdata_o (GAIN_B)");
    read_reg(REG_ADC_A, 0, "rdata_o (ADC_A)");
    read_reg(REG_ADC_B, 0, "rdata_o (ADC_B)");
    check("led_o", 32'(led_o), 0);
    end_test("reset values");

    // Register access, upper wdata bits ignored
    write_reg(REG_CFG, 32'h0000_0003, 1'b0);
    read_reg(REG_CFG, 32'h1, "rdata_o (CFG)");
    write_reg(REG_CFG, 32'h0, 1'b0);
    read_reg(REG_CFG, 32'h0, "rdata_o (CFG)");
    write_reg(REG_LED, 32'hFFFF_FF5A, 1'b0);
    check("led_o", 32'(led_o), 32'h5A);
    read_reg(REG_LED, 32'h5A, "rdata_o (LED)");
    write_reg(REG_SET_A, 32'h0000_2001, 1'b0);
    read_reg(REG_SET_A, 32'hFFFF_E001, "rdata_o (SET_A)");
    write_reg(REG_SET_B, 32'hFFFF_C123, 1'b0);
    read_reg(REG_SET_B, 32'h0000_0123, "rdata_o (SET_B)");
    write_reg(REG_GAIN_A, 32'h0000_8000, 1'b0);
    read_reg(REG_GAIN_A, 32'hFFFF_8000, "rdata_o (GAIN_A)");
    write_reg(REG_GAIN_B, 32'h1234_1000, 1'b0);
    read_reg(REG_GAIN_B, 32'h0000_1000, "rdata_o (GAIN_B)");
    bus_cycle(1'b0, 8'h24, '0, r, pa[0]);  // Unmapped read
    check("err_o", 32'(pa[0]), 32'd1);
    write_reg(8'hFC, 32'hDEAD_BEEF, 1'b1);  // Unmapped write
    write_reg(REG_ADC_A, 32'h0000_1234, 1'b1);
    read_reg(REG_ADC_A, 0, "rdata_o (ADC_A)");
    write_reg(REG_ID, 32'h0, 1'b1);
    read_reg(REG_ID, ID_VALUE, "rdata_o (ID)");
    write_reg(REG_LED, 32'h0, 1'b0);
    write_reg(REG_GAIN_A, 32'h0, 1'b0);
    write_reg(REG_GAIN_B, 32'h0, 1'b0);
    end_test("register access");

    // ADC conversion through readback
    for (int n = 0; n < 8; n++)
    begin
      rand_bits(16, r);
      pa = r[15:0];
      rand_bits(16, r);
      pb = r[15:0];
      @(posedge adc_clk);
      adc_dat_a_i <= pa;
      adc_dat_b_i <= pb;
      read_reg(REG_ADC_A, 32'(adc_value(pa)), "rdata_o (ADC_A)");
      read_reg(REG_ADC_B, 32'(adc_value(pb)), "rdata_o (ADC_B)");
    end
    end_test("ADC conversion");

    apply_rows(0, 4);
    end_test("generator term");
    apply_rows(4, NUM_ROWS);
    end_test("proportional feedback");

    // Loopback replaces pin samples with set-points
    write_reg(REG_CFG, 32'h0, 1'b0);
    write_reg(REG_GAIN_A, 32'h0, 1'b0);
    write_reg(REG_GAIN_B, 32'h0, 1'b0);
    write_reg(REG_SET_A, 32'(3000), 1'b0);
    write_reg(REG_SET_B, 32'(-2500), 1'b0);
    write_reg(REG_CFG, 32'h1, 1'b0);
    for (int n = 0; n < 2; n++)
    begin
      rand_bits(16, r);
      pa = r[15:0];
      rand_bits(16, r);
      pb = r[15:0];
      @(posedge adc_clk);
      adc_dat_a_i <= pa;
      adc_dat_b_i <= pb;
      read_reg(REG_ADC_A, 32'(3000), "rdata_o (ADC_A)");
      read_reg(REG_ADC_B, 32'(-2500), "rdata_o (ADC_B)");
    end
    write_reg(REG_CFG, 32'h0, 1'b0);
    read_reg(REG_ADC_A, 32'(adc_value(pa)), "rdata_o (ADC_A)");
    read_reg(REG_ADC_B, 32'(adc_value(pb)), "rdata_o (ADC_B)");
    end_test("digital loopback");

    $display("Tests %0d, checks %0d, errors %0d", test_no, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_analog_top
